/* hdl/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// lane count and buffer size
`define DECODE_LANES 3
`define SKID_DEPTH   2   // entries per skid buffer

// ------------------------------
// rv64i base opcodes
// ------------------------------
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OPIMM    7'b0010011
`define OPC_OP       7'b0110011
`define OPC_OPIMM32  7'b0011011
`define OPC_OP32     7'b0111011

`endif

/* hdl/decode_pkg.sv */
package decode_pkg;

    // raw fields taken from the instruction word
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } instr_fields_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_src_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2   // link value for jal/jalr
    } result_src_e;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_ctrl_e;

    // ------------------------------
    // control word, msb first
    // ------------------------------
    typedef struct packed {
        logic        regwrite;
        imm_src_e    imsrc;
        logic        uctrl;      // 1 for auipc
        logic        alusrcb;
        logic        memwrite;
        result_src_e resultsrc;
        logic        branch;
        logic        aluop;
        logic [1:0]  size;
        logic        ldext;
        logic        isword;
        logic        jump;
        logic        bjreg;      // jump target from rs1
    } main_ctrl_t;

    typedef struct packed {
        main_ctrl_t main;
        alu_ctrl_e  alucontrol;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        logic       illegal;
    } decode_result_t;

endpackage

/* hdl/decode_ifs.sv */
`timescale 1ns/1ns

// instruction fields, dispatcher to lane
interface instr_if;
    logic       valid;
    logic       ready;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    modport src (
        output valid, opcode, funct3, funct7,
        input  ready
    );

    modport dst (
        input  valid, opcode, funct3, funct7,
        output ready
    );
endinterface

// decoded control, lane to collector
interface ctrl_if;
    logic                   valid;
    logic                   ready;
    decode_pkg::ctrl_word_t ctrl;
    logic                   illegal;

    modport src (
        output valid, ctrl, illegal,
        input  ready
    );

    modport dst (
        input  valid, ctrl, illegal,
        output ready
    );
endinterface

/* hdl/skid_buffer.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module skid_buffer #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);
    localparam int CW = $clog2(`SKID_DEPTH + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] count_nxt;
    logic          in_xfer;
    logic          out_xfer;
    T              skid_data;   // second entry, used only when output stalls

    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign count_nxt = count + CW'(in_xfer) - CW'(out_xfer);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count    <= '0;
            in_ready <= 1'b0;
        end
        else
        begin
            count    <= count_nxt;
            in_ready <= (count_nxt < CW'(`SKID_DEPTH)); // registered, no path from out_ready
        end
    end

    // ------------------------------
    // payload
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!out_valid || out_xfer)
            out_data <= (count == CW'(`SKID_DEPTH)) ? skid_data : in_data;
        if (in_xfer && out_valid && !out_ready)
            skid_data <= in_data;
    end

endmodule

/* hdl/main_decoder.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module main_decoder (
    input  logic [6:0]             opcode,
    input  logic [2:0]             funct3,
    output decode_pkg::main_ctrl_t ctrl,
    output logic                   illegal
);
    always_comb
    begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            `OPC_LUI, `OPC_AUIPC:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.imsrc    = decode_pkg::IMM_U;
                ctrl.alusrcb  = 1'b1;
                ctrl.uctrl    = (opcode == `OPC_AUIPC);
            end
            `OPC_JAL, `OPC_JALR:
            begin
                ctrl.regwrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultsrc = decode_pkg::RES_PC4;
                if (opcode == `OPC_JALR)
                begin
                    ctrl.imsrc = decode_pkg::IMM_I;
                    ctrl.bjreg = 1'b1;
                end
                else
                    ctrl.imsrc = decode_pkg::IMM_J;
            end
            `OPC_BRANCH:
            begin
                ctrl.branch = 1'b1;
                ctrl.imsrc  = decode_pkg::IMM_B;
            end
            `OPC_LOAD:
            begin
                ctrl.regwrite  = 1'b1;
                ctrl.imsrc     = decode_pkg::IMM_I;
                ctrl.alusrcb   = 1'b1;
                ctrl.resultsrc = decode_pkg::RES_MEM;
                ctrl.size      = funct3[1:0];
                ctrl.ldext     = ~funct3[2];   // lbu/lhu/lwu clear bit
            end
            `OPC_STORE:
            begin
                ctrl.memwrite = 1'b1;
                ctrl.imsrc    = decode_pkg::IMM_S;
                ctrl.alusrcb  = 1'b1;
                ctrl.size     = funct3[1:0];
            end
            `OPC_OPIMM, `OPC_OPIMM32:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.imsrc    = decode_pkg::IMM_I;
                ctrl.alusrcb  = 1'b1;
                ctrl.aluop    = 1'b1;
                ctrl.isword   = opcode[3];   // set in the 32-bit forms
            end
            `OPC_OP, `OPC_OP32:
            begin
                ctrl.regwrite = 1'b1;
                ctrl.aluop    = 1'b1;
                ctrl.isword   = opcode[3];
            end
            default: illegal = 1'b1;   // csr, fence, system, anything unknown
        endcase
    end

endmodule

/* hdl/alu_decoder.sv */
`timescale 1ns/1ns

module alu_decoder (
    input  logic [2:0]            funct3,
    input  logic                  aluop,
    input  logic                  funct7_b5,
    input  logic                  opcode_b5,
    output decode_pkg::alu_ctrl_e alucontrol
);
    always_comb
    begin
        alucontrol = decode_pkg::ADD;   // address and upper-immediate adds
        if (aluop)
        begin
            case (funct3)
                3'b000:
                begin
                    // register forms only, addi has no sub
                    if (funct7_b5 && opcode_b5)
                        alucontrol = decode_pkg::SUB;
                    else
                        alucontrol = decode_pkg::ADD;
                end
                3'b001: alucontrol = decode_pkg::SLL;
                3'b010: alucontrol = decode_pkg::SLT;
                3'b011: alucontrol = decode_pkg::SLTU;
                3'b100: alucontrol = decode_pkg::XOR;
                3'b101:
                begin
                    if (funct7_b5)
                        alucontrol = decode_pkg::SRA;
                    else
                        alucontrol = decode_pkg::SRL;
                end
                3'b110: alucontrol = decode_pkg::OR;
                3'b111: alucontrol = decode_pkg::AND;
            endcase
        end
    end

endmodule

/* hdl/decode_lane.sv */
`timescale 1ns/1ns

module decode_lane (
    input  logic   clk,
    input  logic   arst_n,
    instr_if.dst   instr,
    ctrl_if.src    result
);
    decode_pkg::main_ctrl_t     main_ctrl;
    decode_pkg::alu_ctrl_e      alucontrol;
    logic                       illegal;
    decode_pkg::decode_result_t res_in;
    decode_pkg::decode_result_t res_out;

    main_decoder u_main_decoder (
        .opcode  (instr.opcode),
        .funct3  (instr.funct3),
        .ctrl    (main_ctrl),
        .illegal (illegal)
    );

    alu_decoder u_alu_decoder (
        .funct3     (instr.funct3),
        .aluop      (main_ctrl.aluop),
        .funct7_b5  (instr.funct7[5]),
        .opcode_b5  (instr.opcode[5]),
        .alucontrol (alucontrol)
    );

    assign res_in.ctrl.main       = main_ctrl;
    assign res_in.ctrl.alucontrol = alucontrol;
    assign res_in.illegal         = illegal;

    // one cycle through the lane
    skid_buffer #(
        .T (decode_pkg::decode_result_t)
    ) u_out_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (instr.valid),
        .in_ready  (instr.ready),
        .in_data   (res_in),
        .out_valid (result.valid),
        .out_ready (result.ready),
        .out_data  (res_out)
    );

    assign result.ctrl    = res_out.ctrl;
    assign result.illegal = res_out.illegal;

endmodule

/* hdl/decode_dispatch.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_dispatch (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  decode_pkg::instr_fields_t in_fields,
    instr_if.src                      lanes [`DECODE_LANES]
);
    localparam int PW = ($clog2(`DECODE_LANES) > 0) ? $clog2(`DECODE_LANES) : 1;

    logic                      buf_valid;
    logic                      buf_ready;
    decode_pkg::instr_fields_t buf_data;
    logic [`DECODE_LANES-1:0]  lane_ready;
    logic [PW-1:0]             ptr;

    skid_buffer #(
        .T (decode_pkg::instr_fields_t)
    ) u_in_buf (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_fields),
        .out_valid (buf_valid),
        .out_ready (buf_ready),
        .out_data  (buf_data)
    );

    // data fans out to all lanes, valid only to the one under ptr
    for (genvar i = 0; i < `DECODE_LANES; i++)
    begin : g_lane
        assign lanes[i].valid  = buf_valid && (ptr == PW'(i));
        assign lanes[i].opcode = buf_data.opcode;
        assign lanes[i].funct3 = buf_data.funct3;
        assign lanes[i].funct7 = buf_data.funct7;
        assign lane_ready[i]   = lanes[i].ready;
    end

    assign buf_ready = lane_ready[ptr];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ptr <= '0;
        else if (buf_valid && buf_ready)
            ptr <= (ptr == PW'(`DECODE_LANES - 1)) ? '0 : ptr + 1'b1;
    end

endmodule

/* hdl/decode_collect.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_collect (
    input  logic                   clk,
    input  logic                   arst_n,
    ctrl_if.dst                    lanes [`DECODE_LANES],
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::ctrl_word_t out_ctrl,
    output logic                   out_illegal
);
    localparam int PW = ($clog2(`DECODE_LANES) > 0) ? $clog2(`DECODE_LANES) : 1;

    logic [`DECODE_LANES-1:0] lane_valid;
    logic [`DECODE_LANES-1:0] lane_illegal;
    decode_pkg::ctrl_word_t   lane_ctrl [`DECODE_LANES];
    logic [PW-1:0]            ptr;

    // ------------------------------
    // gather lanes, return ready
    // ------------------------------
    for (genvar i = 0; i < `DECODE_LANES; i++)
    begin : g_lane
        assign lane_valid[i]   = lanes[i].valid;
        assign lane_ctrl[i]    = lanes[i].ctrl;
        assign lane_illegal[i] = lanes[i].illegal;
        assign lanes[i].ready  = out_ready && (ptr == PW'(i));
    end

    // same order as the dispatcher, so no reordering
    assign out_valid   = lane_valid[ptr];
    assign out_ctrl    = lane_ctrl[ptr];
    assign out_illegal = lane_illegal[ptr];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ptr <= '0;
        else if (out_valid && out_ready)
            ptr <= (ptr == PW'(`DECODE_LANES - 1)) ? '0 : ptr + 1'b1;
    end

endmodule

/* hdl/decode_top.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [6:0]             in_opcode,
    input  logic [2:0]             in_funct3,
    input  logic [6:0]             in_funct7,
    output logic                   out_valid,
    input  logic                   out_ready,
    output decode_pkg::ctrl_word_t out_ctrl,
    output logic                   out_illegal
);
    instr_if lane_in  [`DECODE_LANES] ();
    ctrl_if  lane_out [`DECODE_LANES] ();

    decode_dispatch u_dispatch (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_fields ({in_opcode, in_funct3, in_funct7}),   // instr_fields_t order
        .lanes     (lane_in)
    );

    // ------------------------------
    // decode lanes
    // ------------------------------
    for (genvar i = 0; i < `DECODE_LANES; i++)
    begin : g_lane
        decode_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .instr  (lane_in[i]),
            .result (lane_out[i])
        );
    end

    decode_collect u_collect (
        .clk         (clk),
        .arst_n      (arst_n),
        .lanes       (lane_out),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_ctrl    (out_ctrl),
        .out_illegal (out_illegal)
    );

endmodule

/* tb/decode_assertions.sv */
`timescale 1ns/1ns

module decode_assertions (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input decode_pkg::ctrl_word_t out_ctrl
);
    // ------------------------------
    // output handshake
    // ------------------------------
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_ctrl))
    else
        $error("out_valid dropped or out_ctrl changed before the transfer");

    a_ctrl_known: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(out_ctrl))
    else
        $error("out_ctrl unknown while out_valid is high");

    // nothing offered or accepted while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !in_ready && !out_valid)
    else
        $error("in_ready or out_valid high during reset");

endmodule

/* tb/decode_tb.sv */
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_tb;
    localparam int n_instr    = 2000;
    localparam int max_cycles = n_instr * 8;   // roughly 4x the expected run

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [6:0]             in_opcode;
    logic [2:0]             in_funct3;
    logic [6:0]             in_funct7;
    logic                   out_valid;
    logic                   out_ready;
    decode_pkg::ctrl_word_t out_ctrl;
    logic                   out_illegal;

    logic [31:0]                lfsr_state = 32'he9f7_59a1;
    int                         issued = 0;
    int                         accepted = 0;
    int                         received = 0;
    int                         cycles = 0;
    int                         stall_left = 0;
    int                         ctrl_errors = 0;
    int                         illegal_errors = 0;
    int                         other_errors = 0;
    bit                         stall_seen = 0;
    decode_pkg::decode_result_t exp_q [$];

    logic [6:0] known_opc [11] = '{`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
        `OPC_LOAD, `OPC_STORE, `OPC_OPIMM, `OPC_OP, `OPC_OPIMM32, `OPC_OP32};
    decode_pkg::alu_ctrl_e alu_base [8] = '{decode_pkg::ADD, decode_pkg::SLL, decode_pkg::SLT,
        decode_pkg::SLTU, decode_pkg::XOR, decode_pkg::SRL, decode_pkg::OR, decode_pkg::AND};

    decode_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_opcode   (in_opcode),
        .in_funct3   (in_funct3),
        .in_funct7   (in_funct7),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_ctrl    (out_ctrl),
        .out_illegal (out_illegal)
    );

    bind decode_top decode_assertions u_assertions (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_ctrl  (out_ctrl)
    );

    // ------------------------------
    // random source and model
    // ------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic decode_pkg::decode_result_t model_decode(
        input logic [6:0] opc,
        input logic [2:0] f3,
        input logic [6:0] f7
    );
        decode_pkg::decode_result_t r;
        logic                       ld;
        logic                       st;
        logic                       jmp;
        logic                       alu;
        r   = '0;
        ld  = (opc == `OPC_LOAD);
        st  = (opc == `OPC_STORE);
        jmp = (opc == `OPC_JAL) || (opc == `OPC_JALR);
        alu = (opc == `OPC_OPIMM) || (opc == `OPC_OP)
              || (opc == `OPC_OPIMM32) || (opc == `OPC_OP32);
        r.illegal = 1'b1;
        foreach (known_opc[i])
            if (known_opc[i] == opc)
                r.illegal = 1'b0;
        if (r.illegal)
            return r;   // all-zero word for an unknown opcode
        r.ctrl.main.regwrite = (opc != `OPC_BRANCH) && !st;
        r.ctrl.main.uctrl    = (opc == `OPC_AUIPC);
        r.ctrl.main.alusrcb  = ld || st || (opc == `OPC_LUI) || (opc == `OPC_AUIPC)
                               || (opc == `OPC_OPIMM) || (opc == `OPC_OPIMM32);
        r.ctrl.main.memwrite = st;
        r.ctrl.main.branch   = (opc == `OPC_BRANCH);
        r.ctrl.main.aluop    = alu;
        r.ctrl.main.size     = (ld || st) ? f3[1:0] : 2'b00;
        r.ctrl.main.ldext    = ld && !f3[2];
        r.ctrl.main.isword   = (opc == `OPC_OPIMM32) || (opc == `OPC_OP32);
        r.ctrl.main.jump     = jmp;
        r.ctrl.main.bjreg    = (opc == `OPC_JALR);
        if (ld)
            r.ctrl.main.resultsrc = decode_pkg::RES_MEM;
        else if (jmp)
            r.ctrl.main.resultsrc = decode_pkg::RES_PC4;
        case (opc)
            `OPC_LUI, `OPC_AUIPC: r.ctrl.main.imsrc = decode_pkg::IMM_U;
            `OPC_JAL:             r.ctrl.main.imsrc = decode_pkg::IMM_J;
            `OPC_BRANCH:          r.ctrl.main.imsrc = decode_pkg::IMM_B;
            `OPC_STORE:           r.ctrl.main.imsrc = decode_pkg::IMM_S;
            default:              r.ctrl.main.imsrc = decode_pkg::IMM_I;
        endcase
        if (alu)
        begin
            r.ctrl.alucontrol = alu_base[f3];
            if (f3 == 3'b000 && f7[5] && opc[5])
                r.ctrl.alucontrol = decode_pkg::SUB;
            if (f3 == 3'b101 && f7[5])
                r.ctrl.alucontrol = decode_pkg::SRA;
        end
        return r;
    endfunction

    task automatic check_ctrl(
        input decode_pkg::ctrl_word_t got,
        input decode_pkg::ctrl_word_t want
    );
        if (got !== want)
        begin
            ctrl_errors++;
            $display("CHECK FAILED at %0t: word %0d ctrl %h, expected %h",
                     $time, received, got, want);
        end
    endtask

    task automatic check_illegal(input logic got, input logic want);
        if (got !== want)
        begin
            illegal_errors++;
            $display("CHECK FAILED at %0t: word %0d illegal %b, expected %b",
                     $time, received, got, want);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // scoreboard sampled at posedge
    // ------------------------------
    always @(posedge clk)
    begin
        decode_pkg::decode_result_t want;
        if (arst_n)
        begin
            cycles++;
            if (in_valid && !in_ready && accepted > 0)
                stall_seen = 1'b1;
            if (in_valid && in_ready)
            begin
                exp_q.push_back(model_decode(in_opcode, in_funct3, in_funct7));
                accepted++;
            end
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    other_errors++;
                    $display("output word at %0t with no matching input", $time);
                end
                else
                begin
                    want = exp_q.pop_front();
                    check_ctrl(out_ctrl, want.ctrl);
                    check_illegal(out_illegal, want.illegal);
                end
                received++;
            end
        end
    end

    initial
    begin
        wait (cycles >= max_cycles);
        $display("timeout after %0d cycles, %0d of %0d words out", cycles, received, n_instr);
        $display("errors: ctrl %0d, illegal %0d, other %0d", ctrl_errors, illegal_errors,
                 other_errors + 1);
        $display("*** FAILED ***");
        $finish;
    end

    // stimulus on the falling edge
    initial
    begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_opcode = '0;
        in_funct3 = '0;
        in_funct7 = '0;
        out_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        while (received < n_instr)
        begin
            @(negedge clk);
            if (accepted == issued)   // nothing pending
            begin
                in_valid = (issued < n_instr) && (rand_bits(2) != 0);
                if (in_valid)
                begin
                    in_opcode = (rand_bits(3) != 0) ? known_opc[rand_bits(4) % 11]
                                                    : 7'(rand_bits(7));
                    in_funct3 = 3'(rand_bits(3));
                    in_funct7 = 7'(rand_bits(7));
                    issued++;
                end
            end
            if (stall_left > 0)
                stall_left--;
            else if (rand_bits(6) == 0)
                stall_left = 20;   // long back-pressure stretch
            out_ready = (stall_left == 0) && (rand_bits(4) < 11);
        end
        out_ready = 1'b1;   // let any extra word out
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0)
        begin
            other_errors++;
            $display("%0d expected words never came out", exp_q.size());
        end
        if (!stall_seen)
        begin
            other_errors++;
            $display("in_ready never dropped under back-pressure");
        end
        $display("errors: ctrl %0d, illegal %0d, other %0d", ctrl_errors, illegal_errors,
                 other_errors);
        if (ctrl_errors + illegal_errors + other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/decode_pkg.sv
hdl/decode_ifs.sv
hdl/skid_buffer.sv
hdl/main_decoder.sv
hdl/alu_decoder.sv
hdl/decode_lane.sv
hdl/decode_dispatch.sv
hdl/decode_collect.sv
hdl/decode_top.sv
tb/decode_assertions.sv
tb/decode_tb.sv

/* Makefile */
TOP := decode_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -qF '*** FAILED ***' sim.log
	grep -qF '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
